//--- build.f
rv_pkg.sv
rv_decoder.sv
rv_imm_gen.sv
rv_regfile.sv
rv_id_ex_reg.sv
rv_id_stage.sv
tb_rv_id_stage.sv

//--- rv_decoder.sv
`timescale 1ns/100ps

module rv_decoder (
    input  rv_pkg::rv_instr_u       instr_i,
    output rv_pkg::rv_ctrl_t        ctrl_o,
    output logic [rv_pkg::XLEN-1:0] csr_zimm_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;        // bit 30, sub / sra
    logic       r_legal;    // funct7 allowed for base R-type

    // shared by OP-IMM and OP
    function automatic logic [4:0] base_alu(input logic [2:0] f3, input logic sel);
        case (f3)
            3'b000:  return sel ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  return rv_pkg::ALU_SLL;
            3'b010:  return rv_pkg::ALU_SLT;
            3'b011:  return rv_pkg::ALU_SLTU;
            3'b100:  return rv_pkg::ALU_XOR;
            3'b101:  return sel ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  return rv_pkg::ALU_OR;
            default: return rv_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode  = instr_i.r.opcode;
    assign funct3  = instr_i.r.funct3;
    assign funct7  = instr_i.r.funct7;
    assign alt     = funct7[5];
    assign r_legal = (funct7 == 7'b0000000) ||
                     (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

    // ========================================
    // main decode
    // ========================================
    always_comb begin
        ctrl_o          = '0;                  // zero codes are the idle defaults
        ctrl_o.csr_addr = instr_i.i.imm12;
        csr_zimm_o      = '0;
        case (opcode)
            rv_pkg::OPC_LOAD: begin
                ctrl_o.imm_type = rv_pkg::IMM_I;
                ctrl_o.op_b_imm = 1'b1;
                ctrl_o.is_load  = 1'b1;
                ctrl_o.wb_src   = rv_pkg::WB_MEM;
                ctrl_o.wb_en    = 1'b1;
                case (funct3)
                    3'b000:  ctrl_o.dmem_type = rv_pkg::DMEM_LB;
                    3'b001:  ctrl_o.dmem_type = rv_pkg::DMEM_LH;
                    3'b010:  ctrl_o.dmem_type = rv_pkg::DMEM_LW;
                    3'b100:  ctrl_o.dmem_type = rv_pkg::DMEM_LBU;
                    3'b101:  ctrl_o.dmem_type = rv_pkg::DMEM_LHU;
                    default: ctrl_o.illegal   = 1'b1;
                endcase
            end
            rv_pkg::OPC_OP_IMM: begin
                ctrl_o.imm_type = rv_pkg::IMM_I;
                ctrl_o.op_b_imm = 1'b1;
                ctrl_o.alu_op   = base_alu(funct3, alt && funct3 == 3'b101);
                ctrl_o.wb_en    = (instr_i != 32'h0000_0013); // canonical nop
            end
            rv_pkg::OPC_AUIPC: begin
                ctrl_o.imm_type = rv_pkg::IMM_U;
                ctrl_o.op_a_pc  = 1'b1;
                ctrl_o.op_b_imm = 1'b1;
                ctrl_o.wb_en    = 1'b1;
            end
            rv_pkg::OPC_STORE: begin
                ctrl_o.imm_type = rv_pkg::IMM_S;
                ctrl_o.op_b_imm = 1'b1;
                case (funct3)
                    3'b000:  ctrl_o.dmem_type = rv_pkg::DMEM_SB;
                    3'b001:  ctrl_o.dmem_type = rv_pkg::DMEM_SH;
                    3'b010:  ctrl_o.dmem_type = rv_pkg::DMEM_SW;
                    default: ctrl_o.illegal   = 1'b1;
                endcase
            end
            rv_pkg::OPC_OP: begin
                ctrl_o.wb_en = 1'b1;
                if (funct7 == 7'b0000001) begin
                    ctrl_o.alu_op = rv_pkg::ALU_MUL | 5'(funct3); // mul .. remu
                end else if (r_legal) begin
                    ctrl_o.alu_op = base_alu(funct3, alt);
                end else begin
                    ctrl_o.illegal = 1'b1;
                end
            end
            rv_pkg::OPC_LUI: begin
                ctrl_o.imm_type = rv_pkg::IMM_U;
                ctrl_o.op_b_imm = 1'b1;
                ctrl_o.wb_src   = rv_pkg::WB_IMM;
                ctrl_o.wb_en    = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                ctrl_o.imm_type  = rv_pkg::IMM_B;
                ctrl_o.is_branch = 1'b1;
                ctrl_o.br_eq     = (funct3 == 3'b000);
                ctrl_o.br_lt     = funct3[2] & ~funct3[0];  // blt, bltu
                case (funct3)
                    3'b000, 3'b001: ctrl_o.alu_op  = rv_pkg::ALU_SUB;
                    3'b100, 3'b101: ctrl_o.alu_op  = rv_pkg::ALU_SLT;
                    3'b110, 3'b111: ctrl_o.alu_op  = rv_pkg::ALU_SLTU;
                    default:        ctrl_o.illegal = 1'b1;
                endcase
            end
            rv_pkg::OPC_JALR: begin
                ctrl_o.imm_type = rv_pkg::IMM_I;
                ctrl_o.op_b_imm = 1'b1;
                ctrl_o.is_jalr  = 1'b1;
                ctrl_o.wb_src   = rv_pkg::WB_PC;
                ctrl_o.wb_en    = 1'b1;
            end
            rv_pkg::OPC_JAL: begin
                ctrl_o.imm_type = rv_pkg::IMM_J;
                ctrl_o.op_a_pc  = 1'b1;
                ctrl_o.op_b_imm = 1'b1;
                ctrl_o.is_jal   = 1'b1;
                ctrl_o.wb_src   = rv_pkg::WB_PC;
                ctrl_o.wb_en    = 1'b1;
            end
            rv_pkg::OPC_SYSTEM: begin
                ctrl_o.wb_src      = rv_pkg::WB_CSR;
                ctrl_o.wb_en       = 1'b1;
                ctrl_o.csr_read    = 1'b1;
                ctrl_o.csr_write   = 1'b1;
                ctrl_o.csr_zimm_en = funct3[2];     // csrr*i forms
                if (funct3[2]) begin
                    csr_zimm_o = {{(rv_pkg::XLEN-5){1'b0}}, instr_i.i.rs1};
                end
                case (funct3[1:0])
                    2'b01: begin                    // csrrw
                        ctrl_o.alu_op     = rv_pkg::ALU_AND;
                        ctrl_o.csr_no_cal = 1'b1;
                    end
                    2'b10: ctrl_o.alu_op = rv_pkg::ALU_OR;  // csrrs
                    2'b11: begin                    // csrrc
                        ctrl_o.alu_op  = rv_pkg::ALU_AND;
                        ctrl_o.csr_inv = 1'b1;
                    end
                    default: ctrl_o.illegal = 1'b1;  // ecall/ebreak space, not handled
                endcase
            end
            default: ctrl_o.illegal = 1'b1;
        endcase

        // illegal words leave no side effects behind
        if (ctrl_o.illegal) begin
            ctrl_o         = '0;
            ctrl_o.illegal = 1'b1;
            csr_zimm_o     = '0;
        end
    end

endmodule

//--- rv_id_ex_reg.sv
`timescale 1ns/100ps

module rv_id_ex_reg (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  logic              flush_i,
    input  logic              valid_i,
    input  rv_pkg::rv_id_ex_t d_i,
    output rv_pkg::rv_id_ex_t q_o
);

    // ========================================
    // flush beats stall beats load
    // ========================================
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o.valid <= 1'b0;           // bubble
            q_o.ctrl  <= '0;
        end else if (!stall_i) begin
            q_o       <= d_i;
            q_o.valid <= valid_i;
        end
    end

    a_stall_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (stall_i && !flush_i) |=> $stable(q_o));

endmodule

//--- rv_id_stage.sv
`timescale 1ns/100ps

module rv_id_stage (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    // fetch side
    input  logic                          instr_valid_i,
    input  rv_pkg::rv_instr_u             instr_i,
    input  logic [rv_pkg::XLEN-1:0]       pc_i,
    // hazard unit
    input  logic                          stall_i,
    input  logic                          flush_i,
    // write-back port
    input  logic                          wb_we_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_i,
    input  logic [rv_pkg::XLEN-1:0]       wb_data_i,
    output rv_pkg::rv_id_ex_t             id_ex_o
);

    rv_pkg::rv_ctrl_t        ctrl;
    rv_pkg::rv_id_ex_t       id_next;
    logic [rv_pkg::XLEN-1:0] imm;
    logic [rv_pkg::XLEN-1:0] csr_zimm;
    logic [rv_pkg::XLEN-1:0] rs1_data;
    logic [rv_pkg::XLEN-1:0] rs2_data;

    rv_decoder i_decoder (
        .instr_i    (instr_i),
        .ctrl_o     (ctrl),
        .csr_zimm_o (csr_zimm)
    );

    rv_imm_gen i_imm_gen (
        .instr_i    (instr_i),
        .imm_type_i (ctrl.imm_type),
        .imm_o      (imm)
    );

    rv_regfile i_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (instr_i.r.rs1),
        .rs2_addr_i (instr_i.r.rs2),
        .we_i       (wb_we_i),
        .rd_addr_i  (wb_rd_i),
        .wd_i       (wb_data_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // ========================================
    // next ID/EX contents
    // ========================================
    always_comb begin
        id_next.valid    = instr_valid_i;
        id_next.pc       = pc_i;
        id_next.rs1_data = rs1_data;
        id_next.rs2_data = rs2_data;
        id_next.imm      = imm;
        id_next.csr_zimm = csr_zimm;
        id_next.rd       = instr_i.r.rd;
        id_next.rs1      = instr_i.r.rs1;
        id_next.rs2      = instr_i.r.rs2;
        id_next.ctrl     = ctrl;
    end

    rv_id_ex_reg i_id_ex_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .valid_i (instr_valid_i),
        .d_i     (id_next),
        .q_o     (id_ex_o)
    );

endmodule

//--- rv_imm_gen.sv
`timescale 1ns/100ps

module rv_imm_gen (
    input  rv_pkg::rv_instr_u       instr_i,
    input  logic [2:0]              imm_type_i,
    output logic [rv_pkg::XLEN-1:0] imm_o
);

    logic       sgn;      // instr bit 31
    logic [6:0] hi;       // bits 31:25
    logic [4:0] lo;       // bits 11:7

    assign sgn = instr_i.s.imm_hi[6];
    assign hi  = instr_i.s.imm_hi;
    assign lo  = instr_i.s.imm_lo;

    always_comb begin
        case (imm_type_i)
            rv_pkg::IMM_I: imm_o = {{20{sgn}}, instr_i.i.imm12};
            rv_pkg::IMM_S: imm_o = {{20{sgn}}, hi, lo};
            rv_pkg::IMM_B: imm_o = {{20{sgn}}, lo[0], hi[5:0], lo[4:1], 1'b0};
            rv_pkg::IMM_U: imm_o = {hi, instr_i.r.rs2, instr_i.r.rs1, instr_i.r.funct3, 12'b0};
            rv_pkg::IMM_J: imm_o = {{12{sgn}}, instr_i.r.rs1, instr_i.r.funct3, // 19:12
                                    instr_i.r.rs2[0],                          // 11
                                    hi[5:0], instr_i.r.rs2[4:1], 1'b0};        // 10:1
            default:       imm_o = '0;
        endcase
    end

endmodule

//--- rv_pkg.sv
package rv_pkg;

    // ========================================
    // widths and major opcodes
    // ========================================
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // ========================================
    // ALU, immediate, write-back, dmem codes
    // ========================================
    localparam logic [4:0] ALU_ADD    = 5'd0;
    localparam logic [4:0] ALU_SUB    = 5'd1;
    localparam logic [4:0] ALU_SLL    = 5'd2;
    localparam logic [4:0] ALU_SLT    = 5'd3;
    localparam logic [4:0] ALU_SLTU   = 5'd4;
    localparam logic [4:0] ALU_XOR    = 5'd5;
    localparam logic [4:0] ALU_SRL    = 5'd6;
    localparam logic [4:0] ALU_SRA    = 5'd7;
    localparam logic [4:0] ALU_OR     = 5'd8;
    localparam logic [4:0] ALU_AND    = 5'd9;
    // M group sits at 16 + funct3
    localparam logic [4:0] ALU_MUL    = 5'd16;
    localparam logic [4:0] ALU_MULH   = 5'd17;
    localparam logic [4:0] ALU_MULHSU = 5'd18;
    localparam logic [4:0] ALU_MULHU  = 5'd19;
    localparam logic [4:0] ALU_DIV    = 5'd20;
    localparam logic [4:0] ALU_DIVU   = 5'd21;
    localparam logic [4:0] ALU_REM    = 5'd22;
    localparam logic [4:0] ALU_REMU   = 5'd23;

    localparam logic [2:0] IMM_NONE = 3'd0;
    localparam logic [2:0] IMM_I    = 3'd1;
    localparam logic [2:0] IMM_S    = 3'd2;
    localparam logic [2:0] IMM_B    = 3'd3;
    localparam logic [2:0] IMM_U    = 3'd4;
    localparam logic [2:0] IMM_J    = 3'd5;

    localparam logic [2:0] WB_ALU = 3'd0;
    localparam logic [2:0] WB_MEM = 3'd1;
    localparam logic [2:0] WB_IMM = 3'd2;
    localparam logic [2:0] WB_PC  = 3'd3;
    localparam logic [2:0] WB_CSR = 3'd4;

    localparam logic [3:0] DMEM_NONE = 4'd0;
    localparam logic [3:0] DMEM_LB   = 4'd1;
    localparam logic [3:0] DMEM_LH   = 4'd2;
    localparam logic [3:0] DMEM_LW   = 4'd3;
    localparam logic [3:0] DMEM_LBU  = 4'd4;
    localparam logic [3:0] DMEM_LHU  = 4'd5;
    localparam logic [3:0] DMEM_SB   = 4'd6;
    localparam logic [3:0] DMEM_SH   = 4'd7;
    localparam logic [3:0] DMEM_SW   = 4'd8;

    // ========================================
    // instruction formats and stage bundles
    // ========================================
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
    } rv_instr_u;

    typedef struct packed {
        logic [4:0]            alu_op;
        logic                  op_a_pc;    // operand a is pc
        logic                  op_b_imm;   // operand b is imm
        logic [2:0]            imm_type;
        logic                  is_branch;
        logic                  br_eq;
        logic                  br_lt;
        logic                  is_jal;
        logic                  is_jalr;
        logic                  is_load;
        logic [3:0]            dmem_type;
        logic [2:0]            wb_src;
        logic                  wb_en;
        logic [CSR_ADDR_W-1:0] csr_addr;
        logic                  csr_read;
        logic                  csr_write;
        logic                  csr_inv;    // clear-bits variant
        logic                  csr_no_cal; // plain swap
        logic                  csr_zimm_en;
        logic                  illegal;
    } rv_ctrl_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       csr_zimm;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        rv_ctrl_t              ctrl;
    } rv_id_ex_t;

endpackage

//--- rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    input  logic                          we_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rd_addr_i,
    input  logic [rv_pkg::XLEN-1:0]       wd_i,
    output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]       rs2_data_o
);

    localparam int NREGS = 2 ** rv_pkg::REG_ADDR_W;

    logic [rv_pkg::XLEN-1:0] regs [1:NREGS-1];  // x0 has no storage
    logic                    wr_live;

    assign wr_live = we_i && (rd_addr_i != '0);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[rd_addr_i] <= wd_i;
        end
    end

    // one read port, with write-back bypass
    function automatic logic [rv_pkg::XLEN-1:0] rd_port(
        input logic [rv_pkg::REG_ADDR_W-1:0] addr
    );
        if (addr == '0) return '0;
        if (wr_live && addr == rd_addr_i) return wd_i;
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data_o = rd_port(rs1_addr_i);
        rs2_data_o = rd_port(rs2_addr_i);
    end

    property p_x0_zero(addr, data);
        @(posedge clk_i) disable iff (!rst_n_i)
            (addr == '0 && !$isunknown(data)) |-> (data == '0);
    endproperty

    a_x0_rs1: assert property (p_x0_zero(rs1_addr_i, rs1_data_o));
    a_x0_rs2: assert property (p_x0_zero(rs2_addr_i, rs2_data_o));

endmodule

//--- tb_rv_id_stage.sv
`timescale 1ns/100ps

module tb_rv_id_stage;

    localparam int N_RF  = 40;
    localparam int N_IMM = 64;
    // reset, regfile, immediate, decode, r-type, nop/srai, pipeline
    localparam int N_VEC = 5 + N_RF + 18 + N_IMM + 11 * 8 + 3 * 8 + 2 + 12;

    logic                          clk;
    logic                          rst_n;
    logic                          instr_valid;
    rv_pkg::rv_instr_u             instr;
    logic [rv_pkg::XLEN-1:0]       pc;
    logic                          stall;
    logic                          flush;
    logic                          wb_we;
    logic [rv_pkg::REG_ADDR_W-1:0] wb_rd;
    logic [rv_pkg::XLEN-1:0]       wb_data;
    rv_pkg::rv_id_ex_t             id_ex;

    logic [31:0]       rng = 32'h14b9;
    logic [31:0]       shadow [0:31];     // reference copy of the register file
    rv_pkg::rv_id_ex_t exp_d;             // expected after the next rising edge
    rv_pkg::rv_id_ex_t exp_q;
    logic              chk_q;
    string             cur_name;
    string             name_q;
    logic              nx_stall;          // side inputs for the next step
    logic              nx_flush;
    logic              nx_we;
    logic [4:0]        nx_rd;
    logic [31:0]       nx_data;

    logic [4:0] alu_map [0:7] = '{rv_pkg::ALU_ADD, rv_pkg::ALU_SLL, rv_pkg::ALU_SLT,
        rv_pkg::ALU_SLTU, rv_pkg::ALU_XOR, rv_pkg::ALU_SRL, rv_pkg::ALU_OR, rv_pkg::ALU_AND};
    logic [4:0] m_map [0:7] = '{rv_pkg::ALU_MUL, rv_pkg::ALU_MULH, rv_pkg::ALU_MULHSU,
        rv_pkg::ALU_MULHU, rv_pkg::ALU_DIV, rv_pkg::ALU_DIVU, rv_pkg::ALU_REM,
        rv_pkg::ALU_REMU};
    logic [3:0] load_map [0:7] = '{rv_pkg::DMEM_LB, rv_pkg::DMEM_LH, rv_pkg::DMEM_LW,
        rv_pkg::DMEM_NONE, rv_pkg::DMEM_LBU, rv_pkg::DMEM_LHU, rv_pkg::DMEM_NONE,
        rv_pkg::DMEM_NONE};
    logic [3:0] store_map [0:7] = '{rv_pkg::DMEM_SB, rv_pkg::DMEM_SH, rv_pkg::DMEM_SW,
        rv_pkg::DMEM_NONE, rv_pkg::DMEM_NONE, rv_pkg::DMEM_NONE, rv_pkg::DMEM_NONE,
        rv_pkg::DMEM_NONE};
    logic [6:0] imm_opc [0:7] = '{rv_pkg::OPC_LOAD, rv_pkg::OPC_OP_IMM, rv_pkg::OPC_JALR,
        rv_pkg::OPC_STORE, rv_pkg::OPC_BRANCH, rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC,
        rv_pkg::OPC_JAL};
    logic [6:0] dec_opc [0:10] = '{rv_pkg::OPC_LOAD, rv_pkg::OPC_OP_IMM, rv_pkg::OPC_AUIPC,
        rv_pkg::OPC_STORE, rv_pkg::OPC_LUI, rv_pkg::OPC_BRANCH, rv_pkg::OPC_JALR,
        rv_pkg::OPC_JAL, rv_pkg::OPC_SYSTEM, 7'h7f, 7'h0b};   // last two unknown
    logic [6:0] r_f7 [0:2] = '{7'b0000000, 7'b0100000, 7'b0000001};

    rv_id_stage i_dut (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .pc_i          (pc),
        .stall_i       (stall),
        .flush_i       (flush),
        .wb_we_i       (wb_we),
        .wb_rd_i       (wb_rd),
        .wb_data_i     (wb_data),
        .id_ex_o       (id_ex)
    );

    // ========================================
    // reference rules
    // ========================================
    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic rv_pkg::rv_ctrl_t ref_ctrl(input logic [31:0] w);
        rv_pkg::rv_ctrl_t c;
        logic [2:0]       f3;
        logic [6:0]       f7;
        f3 = w[14:12];
        f7 = w[31:25];
        c = '0;
        c.csr_addr = w[31:20];
        case (w[6:0])
            rv_pkg::OPC_LOAD: begin
                c.imm_type  = rv_pkg::IMM_I;
                c.op_b_imm  = 1'b1;
                c.is_load   = 1'b1;
                c.wb_src    = rv_pkg::WB_MEM;
                c.wb_en     = 1'b1;
                c.dmem_type = load_map[f3];
                c.illegal   = (load_map[f3] == rv_pkg::DMEM_NONE);
            end
            rv_pkg::OPC_OP_IMM: begin
                c.imm_type = rv_pkg::IMM_I;
                c.op_b_imm = 1'b1;
                c.alu_op   = (f3 == 3'b101 && w[30]) ? rv_pkg::ALU_SRA : alu_map[f3];
                c.wb_en    = (w != 32'h0000_0013);   // canonical nop writes nothing
            end
            rv_pkg::OPC_STORE: begin
                c.imm_type  = rv_pkg::IMM_S;
                c.op_b_imm  = 1'b1;
                c.dmem_type = store_map[f3];
                c.illegal   = (store_map[f3] == rv_pkg::DMEM_NONE);
            end
            rv_pkg::OPC_OP: begin
                c.wb_en = 1'b1;
                if (f7 == 7'b0000001) begin
                    c.alu_op = m_map[f3];   // m extension
                end else if (f7 == 7'b0000000) begin
                    c.alu_op = alu_map[f3];
                end else if (f7 == 7'b0100000 && f3 == 3'b000) begin
                    c.alu_op = rv_pkg::ALU_SUB;
                end else if (f7 == 7'b0100000 && f3 == 3'b101) begin
                    c.alu_op = rv_pkg::ALU_SRA;
                end else begin
                    c.illegal = 1'b1;
                end
            end
            rv_pkg::OPC_AUIPC, rv_pkg::OPC_LUI, rv_pkg::OPC_JAL: begin
                c.imm_type = (w[6:0] == rv_pkg::OPC_JAL) ? rv_pkg::IMM_J : rv_pkg::IMM_U;
                c.op_a_pc  = (w[6:0] != rv_pkg::OPC_LUI);
                c.op_b_imm = 1'b1;
                c.is_jal   = (w[6:0] == rv_pkg::OPC_JAL);
                c.wb_src   = (w[6:0] == rv_pkg::OPC_LUI) ? rv_pkg::WB_IMM :
                             (w[6:0] == rv_pkg::OPC_JAL) ? rv_pkg::WB_PC : rv_pkg::WB_ALU;
                c.wb_en    = 1'b1;
            end
            rv_pkg::OPC_JALR: begin
                c.imm_type = rv_pkg::IMM_I;
                c.op_b_imm = 1'b1;
                c.is_jalr  = 1'b1;
                c.wb_src   = rv_pkg::WB_PC;
                c.wb_en    = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                c.imm_type  = rv_pkg::IMM_B;
                c.is_branch = 1'b1;
                c.br_eq     = (f3 == 3'b000);
                c.br_lt     = (f3 == 3'b100 || f3 == 3'b110);
                c.alu_op    = !f3[2] ? rv_pkg::ALU_SUB :
                              (f3[1] ? rv_pkg::ALU_SLTU : rv_pkg::ALU_SLT);
                c.illegal   = (f3 == 3'b010 || f3 == 3'b011);
            end
            rv_pkg::OPC_SYSTEM: begin
                c.wb_src      = rv_pkg::WB_CSR;
                c.wb_en       = 1'b1;
                c.csr_read    = 1'b1;
                c.csr_write   = 1'b1;
                c.csr_zimm_en = f3[2];
                c.csr_no_cal  = (f3[1:0] == 2'b01);   // csrrw
                c.csr_inv     = (f3[1:0] == 2'b11);   // csrrc
                c.alu_op      = (f3[1:0] == 2'b10) ? rv_pkg::ALU_OR : rv_pkg::ALU_AND;
                c.illegal     = (f3[1:0] == 2'b00);
            end
            default: c.illegal = 1'b1;
        endcase
        if (c.illegal) begin
            c = '0;
            c.illegal = 1'b1;
        end
        return c;
    endfunction

    function automatic logic [31:0] ref_imm(input logic [31:0] w, input logic [2:0] t);
        case (t)
            rv_pkg::IMM_I: return {{20{w[31]}}, w[31:20]};
            rv_pkg::IMM_S: return {{20{w[31]}}, w[31:25], w[11:7]};
            rv_pkg::IMM_B: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            rv_pkg::IMM_U: return {w[31:12], 12'b0};
            rv_pkg::IMM_J: return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:       return '0;
        endcase
    endfunction

    function automatic logic [31:0] reg_read(input logic [4:0] a);
        if (a == '0) return '0;
        if (wb_we && wb_rd == a) return wb_data;   // same-cycle write
        return shadow[a];
    endfunction

    task automatic predict();
        rv_pkg::rv_id_ex_t d;
        logic [31:0]       w;
        w = instr;
        d.valid    = instr_valid;
        d.pc       = pc;
        d.rs1_data = reg_read(w[19:15]);
        d.rs2_data = reg_read(w[24:20]);
        d.ctrl     = ref_ctrl(w);
        d.imm      = ref_imm(w, d.ctrl.imm_type);
        d.csr_zimm = d.ctrl.csr_zimm_en ? {27'd0, w[19:15]} : 32'd0;
        d.rd       = w[11:7];
        d.rs1      = w[19:15];
        d.rs2      = w[24:20];
        if (flush) begin
            exp_d       = exp_q;
            exp_d.valid = 1'b0;
            exp_d.ctrl  = '0;
        end else if (stall) begin
            exp_d = exp_q;
        end else begin
            exp_d = d;
        end
    endtask

    task automatic step(input string name, input logic vld, input logic [31:0] w);
        @(negedge clk);
        instr_valid = vld;
        instr       = w;
        pc          = {30'(next_rand() >> 2), 2'b00};
        stall       = nx_stall;
        flush       = nx_flush;
        wb_we       = nx_we;
        wb_rd       = nx_rd;
        wb_data     = nx_data;
        cur_name    = name;
        predict();
        nx_stall = 1'b0;
        nx_flush = 1'b0;
        nx_we    = 1'b0;
    endtask

    task automatic report_mismatch(input string name, input logic [255:0] expv,
                                   input logic [255:0] actv);
        $display("CHECK FAILED %s expected %h actual %h", name, expv, actv);
        $display("Result: FAILED");
        $fatal(1, "id stage output mismatch");
    endtask

    // ========================================
    // expected-value pipeline and checks
    // ========================================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_q <= '0;
            chk_q <= 1'b0;
        end else begin
            exp_q  <= exp_d;
            chk_q  <= 1'b1;
            name_q <= cur_name;
        end
    end

    always @(posedge clk) begin
        if (rst_n && wb_we && wb_rd != '0) shadow[wb_rd] <= wb_data;
    end

    a_reset_state: assert property (@(negedge clk)
        !rst_n |-> (!id_ex.valid && id_ex.ctrl == '0))
        else report_mismatch("reset state", '0, {id_ex.valid, id_ex.ctrl});

    a_id_ex_match: assert property (@(negedge clk) disable iff (!rst_n)
        chk_q |-> (id_ex == exp_q))
        else report_mismatch(name_q, exp_q, id_ex);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #((N_VEC + 50) * 4);
        $display("timeout: the tests did not finish in the expected time");
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    // ========================================
    // stimulus
    // ========================================
    initial begin : stimulus
        logic [31:0] w;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        wb_we       = 1'b0;
        wb_rd       = '0;
        wb_data     = '0;
        nx_stall    = 1'b0;
        nx_flush    = 1'b0;
        nx_we       = 1'b0;
        nx_rd       = '0;
        nx_data     = '0;
        cur_name    = "after reset";
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        predict();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // rs2 follows the written register so the bypass is hit
        for (int i = 0; i < N_RF; i++) begin
            w       = next_rand();
            nx_we   = 1'b1;
            nx_rd   = w[4:0];
            nx_data = next_rand();
            step("regfile write", 1'b1, {7'h00, w[4:0], w[9:5], 3'b000, w[14:10], 7'h33});
        end
        nx_we   = 1'b1;
        nx_rd   = 5'd0;
        nx_data = 32'hdead_beef;
        step("x0 write", 1'b1, {7'h00, 5'd0, 5'd0, 3'b000, 5'd1, rv_pkg::OPC_OP});
        step("x0 read", 1'b1, {7'h00, 5'd0, 5'd0, 3'b000, 5'd1, rv_pkg::OPC_OP});
        for (int r = 0; r < 32; r += 2) begin
            step("regfile read", 1'b1, {7'h00, 5'(r + 1), 5'(r), 3'b000, 5'd3, rv_pkg::OPC_OP});
        end

        for (int i = 0; i < N_IMM; i++) begin
            w      = next_rand();
            w[6:0] = imm_opc[i % 8];
            step("immediate", 1'b1, w);
        end

        // every funct3 of each opcode, illegal ones included
        for (int k = 0; k < 11; k++) begin
            for (int f = 0; f < 8; f++) begin
                w = next_rand();
                step($sformatf("decode opcode %h funct3 %0d", dec_opc[k], f), 1'b1,
                     {w[31:15], 3'(f), w[11:7], dec_opc[k]});
            end
        end
        for (int k = 0; k < 3; k++) begin
            for (int f = 0; f < 8; f++) begin
                w = next_rand();
                step($sformatf("decode funct7 %h funct3 %0d", r_f7[k], f), 1'b1,
                     {r_f7[k], w[24:15], 3'(f), w[11:7], rv_pkg::OPC_OP});
            end
        end
        step("nop", 1'b1, 32'h0000_0013);
        step("srai", 1'b1, 32'h4030_d093);

        step("load before stall", 1'b1, {25'(next_rand() >> 7), rv_pkg::OPC_OP_IMM});
        repeat (4) begin
            nx_stall = 1'b1;
            step("stall hold", 1'b1, {25'(next_rand() >> 7), rv_pkg::OPC_LUI});
        end
        nx_stall = 1'b1;
        nx_flush = 1'b1;
        step("flush during stall", 1'b1, {25'(next_rand() >> 7), rv_pkg::OPC_JAL});
        nx_flush = 1'b1;
        step("flush", 1'b1, {25'(next_rand() >> 7), rv_pkg::OPC_AUIPC});
        step("valid low", 1'b0, {25'(next_rand() >> 7), rv_pkg::OPC_OP_IMM});
        step("idle", 1'b0, 32'h0000_0013);
        repeat (2) @(negedge clk);   // last compare has run
        $display("Result: PASSED");
        $finish;
    end

endmodule
